// File: flist.f
+incdir+include
verilog/mine_pkg.sv
verilog/apb_regs_pkg.sv
verilog/block_storage.sv
verilog/sha256_core.sv
verilog/mine_ctrl.sv
verilog/apb_miner_regs.sv
verilog/miner_top.sv
tests/miner_assert.sv
tests/tb_miner.sv

// File: include/miner_defs.svh
// Slot offsets assume a 12-bit APB byte address with one storage byte per 32-bit word
`ifndef MINER_DEFS_SVH
`define MINER_DEFS_SVH

// Block storage layout in bytes
`define STORE_BYTES 112
`define CHUNK1_BYTES 64
`define CHUNK2_BYTES 16
`define TARGET_BYTES 32

// Compression rounds per 512-bit block
`define SHA_ROUNDS 64

// Control and status register offsets
`define REG_CTRL 12'h200
`define REG_NONCE_START 12'h204
`define REG_NONCE_COUNT 12'h208
`define REG_STATUS 12'h20C
`define REG_FOUND 12'h210

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the miner testbench with Verilator, result taken from sim.log
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_miner -f flist.f -o tb_miner_sim
./obj_dir/tb_miner_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
if grep -q "TEST PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: tests/miner_assert.sv
// Bound into miner_top; in-flight tracking assumes blk_start never shares a cycle with hash_done
`timescale 1ns/1ps

module miner_assert import mine_pkg::*; (
	input logic        tb_clk,
	input logic        rst_n,
	input logic        psel,
	input logic        penable,
	input logic        pready,
	input logic        pslverr,
	input logic        busy,
	input logic        done,
	input logic        blk_start,
	input logic        hash_done,
	input mine_state_t ctrl_state
);

	// Count of failed assertions
	int unsigned fail_count = 0;
	// Core holds a block between blk_start and hash_done
	logic in_flight;

	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
			in_flight <= 1'b0;
		else if (blk_start)
			in_flight <= 1'b1;
		else if (hash_done)
			in_flight <= 1'b0;
	end

	// Zero wait states
	a_pready: assert property (@(posedge tb_clk) disable iff (!rst_n) pready)
		else
		begin
			$error("pready dropped low");
			fail_count++;
		end

	a_busy_done: assert property (@(posedge tb_clk) disable iff (!rst_n) !(busy && done))
		else
		begin
			$error("busy and done high together");
			fail_count++;
		end

	// Core results only arrive while the FSM waits on a hash
	a_done_wait: assert property (@(posedge tb_clk) disable iff (!rst_n)
		hash_done |-> ((ctrl_state == MIDSTATE) || (ctrl_state == INNER)
			|| (ctrl_state == OUTER)))
		else
		begin
			$error("hash_done while controller not waiting on the core");
			fail_count++;
		end

	a_single_issue: assert property (@(posedge tb_clk) disable iff (!rst_n)
		blk_start |-> !in_flight)
		else
		begin
			$error("blk_start while core is mid-hash");
			fail_count++;
		end

	a_pslverr_phase: assert property (@(posedge tb_clk) disable iff (!rst_n)
		pslverr |-> (psel && penable))
		else
		begin
			$error("pslverr outside an access phase");
			fail_count++;
		end

endmodule

bind miner_top miner_assert u_assert (
	.tb_clk, .rst_n, .psel, .penable, .pready, .pslverr,
	.busy, .done, .blk_start, .hash_done,
	.ctrl_state(u_ctrl.state)
);

// File: tests/tb_miner.sv
// Needs --timing; one idle cycle between APB transfers, status polled with a bounded loop
`timescale 1ns/1ps
`include "miner_defs.svh"

module tb_miner;

	// Public genesis header, nonce field cleared
	localparam logic [639:0] GENESIS_HDR = {
		32'h01000000,
		256'h0,
		256'h3ba3edfd7a7b12b27ac72c3e67768f617fc81bc3888a51323a9fb8aa4b1e5e4a,
		32'h29ab5f49,
		32'hffff001d,
		32'h00000000
	};
	localparam logic [31:0] GENESIS_NONCE = 32'h7c2bac1d;
	localparam int POLL_LIMIT = 2000;

	logic        tb_clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	int          errors;
	// Expected slot contents for the round trip
	logic [7:0]  slot_data [`STORE_BYTES];

	miner_top u_miner_top (
		.tb_clk, .rst_n,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
	);

	// 10 ns period
	always #5 tb_clk = ~tb_clk;

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			errors++;
			$display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
		end
	endtask

	// Setup then access phase, outputs sampled inside the access phase
	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge tb_clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge tb_clk);
		penable = 1'b1;
		#1;
		rdata = prdata;
		err = pslverr;
		@(negedge tb_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata, output logic err);
		logic [31:0] rd_unused;
		apb_xfer(1'b1, addr, wdata, rd_unused, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, input logic exp_err,
		output logic [31:0] rdata);
		logic err;
		apb_xfer(1'b0, addr, 32'd0, rdata, err);
		check_eq($sformatf("pslverr@0x%h", addr), 32'(exp_err), 32'(err));
	endtask

	task automatic write_expect(input logic [11:0] addr, input logic [31:0] wdata,
		input logic exp_err);
		logic err;
		apb_write(addr, wdata, err);
		check_eq($sformatf("pslverr@0x%h", addr), 32'(exp_err), 32'(err));
	endtask

	// Header in slots 0..79, target in 80..111
	task automatic load_job(input logic zero_target);
		for (int i = 0; i < `CHUNK1_BYTES + `CHUNK2_BYTES; i++)
			write_expect(12'(i * 4), 32'(GENESIS_HDR[639 - 8*i -: 8]), 1'b0);
		// Genesis target is 0xffff in target bytes 26 and 27
		for (int i = 0; i < `TARGET_BYTES; i++)
			write_expect(12'((`CHUNK1_BYTES + `CHUNK2_BYTES + i) * 4),
				(!zero_target && (i == 26 || i == 27)) ? 32'hff : 32'h0, 1'b0);
	endtask

	task automatic wait_done(output logic [31:0] status);
		int polls;
		polls = 0;
		status = '0;
		while (!status[1] && (polls < POLL_LIMIT))
		begin
			apb_read(`REG_STATUS, 1'b0, status);
			polls++;
		end
		if (!status[1])
		begin
			errors++;
			$display("Timeout: search still running after %0d status polls", POLL_LIMIT);
		end
	endtask

	task automatic run_job(input logic [31:0] first, input logic [31:0] count,
		output logic [31:0] status);
		write_expect(`REG_NONCE_START, first, 1'b0);
		write_expect(`REG_NONCE_COUNT, count, 1'b0);
		write_expect(`REG_CTRL, 32'h1, 1'b0);
		wait_done(status);
	endtask

	task automatic test_storage_round_trip();
		logic [31:0] rd;
		for (int i = 0; i < `STORE_BYTES; i++)
		begin
			slot_data[i] = 8'($urandom);
			write_expect(12'(i * 4), {24'd0, slot_data[i]}, 1'b0);
		end
		for (int i = 0; i < `STORE_BYTES; i++)
		begin
			apb_read(12'(i * 4), 1'b0, rd);
			check_eq($sformatf("slot[%0d]", i), {24'd0, slot_data[i]}, rd);
		end
	endtask

	task automatic test_address_errors();
		logic [31:0] rd;
		apb_read(12'h1c0, 1'b1, rd);
		apb_read(12'h3fc, 1'b1, rd);
		// Nothing started yet, status all clear
		apb_read(`REG_STATUS, 1'b0, rd);
		check_eq("status", 32'h0, rd);
	endtask

	task automatic test_genesis_block();
		logic [31:0] st;
		logic [31:0] rd;
		load_job(1'b0);
		run_job(32'h7c2bac1a, 32'd8, st);
		// done and found, busy clear
		check_eq("status", 32'h6, st);
		apb_read(`REG_FOUND, 1'b0, rd);
		check_eq("found_nonce", GENESIS_NONCE, rd);
	endtask

	task automatic test_exhausted_search();
		logic [31:0] st;
		load_job(1'b1);
		run_job(32'h7c2bac1a, 32'd3, st);
		check_eq("status", 32'h2, st);
	endtask

	// Reuses the zero-target job left in storage
	task automatic test_busy_protection();
		logic [31:0] st;
		logic [31:0] rd;
		write_expect(`REG_CTRL, 32'h1, 1'b0);
		write_expect(12'h000, 32'ha5, 1'b1);
		write_expect(`REG_CTRL, 32'h1, 1'b1);
		wait_done(st);
		check_eq("status", 32'h2, st);
		apb_read(12'h000, 1'b0, rd);
		check_eq("slot[0]", 32'(GENESIS_HDR[639 -: 8]), rd);
	endtask

	initial
	begin
		errors = 0;
		tb_clk = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		void'($urandom(32'h95b2));
		repeat (5) @(negedge tb_clk);
		rst_n = 1'b1;
		test_storage_round_trip();
		test_address_errors();
		test_genesis_block();
		test_exhausted_search();
		test_busy_protection();
		$display("Run complete: %0d check errors, %0d assertion failures",
			errors, u_miner_top.u_assert.fail_count);
		if ((errors == 0) && (u_miner_top.u_assert.fail_count == 0))
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: verilog/apb_miner_regs.sv
// Zero-wait APB3 slave; writes to STATUS and FOUND are ignored, slot data in PWDATA bits 7:0
`timescale 1ns/1ps
`include "miner_defs.svh"

module apb_miner_regs import apb_regs_pkg::*; (
	input  logic                          tb_clk,
	input  logic                          rst_n,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [11:0]                   paddr,
	input  logic [31:0]                   pwdata,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output logic                          pslverr,
	output logic                          data_en,
	output logic [6:0]                    data_sel,
	output logic [7:0]                    data,
	input  logic [`CHUNK1_BYTES-1:0][7:0] chunk_1,
	input  logic [`CHUNK2_BYTES-1:0][7:0] chunk_2,
	input  logic [`TARGET_BYTES-1:0][7:0] difficulty,
	output logic                          start,
	output logic [31:0]                   nonce_start,
	output logic [31:0]                   nonce_count,
	input  logic                          busy,
	input  logic                          done,
	input  logic                          found,
	input  logic [31:0]                   found_nonce
);

	reg_sel_t                     sel;
	logic                         access;
	logic [`STORE_BYTES-1:0][7:0] store_view;

	// Access phase, always one cycle
	assign access = psel && penable;
	assign pready = 1'b1;
	assign store_view = {difficulty, chunk_2, chunk_1};

	// Address decode, slots word aligned below the registers
	always_comb
	begin
		sel = BAD;
		if (paddr < 12'(`STORE_BYTES * 4))
			sel = (paddr[1:0] == 2'b00) ? SLOT : BAD;
		else
			case (paddr)
				`REG_CTRL:        sel = CTRL;
				`REG_NONCE_START: sel = NONCE_START;
				`REG_NONCE_COUNT: sel = NONCE_COUNT;
				`REG_STATUS:      sel = STATUS;
				`REG_FOUND:       sel = FOUND;
				default:          sel = BAD;
			endcase
	end

	// Slot write to storage, blocked during a search
	assign data_en = access && pwrite && (sel == SLOT) && !busy;
	assign data_sel = paddr[8:2];
	assign data = pwdata[7:0];

	// CTRL bit 0 starts a job
	assign start = access && pwrite && (sel == CTRL) && pwdata[0] && !busy;

	assign pslverr = access && ((sel == BAD)
		|| (pwrite && busy && ((sel == SLOT) || ((sel == CTRL) && pwdata[0]))));

	// Nonce range registers
	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			nonce_start <= '0;
			nonce_count <= '0;
		end
		else if (access && pwrite)
		begin
			if (sel == NONCE_START)
				nonce_start <= pwdata;
			if (sel == NONCE_COUNT)
				nonce_count <= pwdata;
		end
	end

	// Read mux
	always_comb
	begin
		case (sel)
			SLOT:        prdata = {24'd0, store_view[paddr[8:2]]};
			NONCE_START: prdata = nonce_start;
			NONCE_COUNT: prdata = nonce_count;
			STATUS:      prdata = {29'd0, found, done, busy};
			FOUND:       prdata = found_nonce;
			default:     prdata = '0;
		endcase
	end

endmodule

// File: verilog/apb_regs_pkg.sv
// Host-side access kinds; BAD covers unaligned slots and unmapped offsets
package apb_regs_pkg;

	// Decoded APB access kind
	typedef enum logic [2:0] {
		SLOT,
		CTRL,
		NONCE_START,
		NONCE_COUNT,
		STATUS,
		FOUND,
		BAD
	} reg_sel_t;

endpackage

// File: verilog/block_storage.sv
// Writes to slots at or above STORE_BYTES are dropped; a written byte shows on the next cycle
`timescale 1ns/1ps
`include "miner_defs.svh"

module block_storage (
	input  logic                           tb_clk,
	input  logic                           rst_n,
	input  logic                           data_en,
	input  logic [6:0]                     data_sel,
	input  logic [7:0]                     data,
	output logic [`CHUNK1_BYTES-1:0][7:0]  chunk_1,
	output logic [`CHUNK2_BYTES-1:0][7:0]  chunk_2,
	output logic [`TARGET_BYTES-1:0][7:0]  difficulty
);

	// Flat byte array, slot n at index n
	logic [`STORE_BYTES-1:0][7:0] mem;

	// One byte per enabled cycle
	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mem <= '0;
		end
		else if (data_en && (data_sel < 7'(`STORE_BYTES)))
		begin
			mem[data_sel] <= data;
		end
	end

	// Header bytes 0 to 63
	assign chunk_1 = mem[`CHUNK1_BYTES-1:0];
	// Header bytes 64 to 79, nonce field included
	assign chunk_2 = mem[`CHUNK1_BYTES+`CHUNK2_BYTES-1:`CHUNK1_BYTES];
	// Target bytes, least significant first
	assign difficulty = mem[`STORE_BYTES-1:`CHUNK1_BYTES+`CHUNK2_BYTES];

endmodule

// File: verilog/mine_ctrl.sv
// Nonce lands LE in header bytes 76..79; nonce_count of zero ends the job after the midstate
`timescale 1ns/1ps
`include "miner_defs.svh"

module mine_ctrl import mine_pkg::*; (
	input  logic                          tb_clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  logic [31:0]                   nonce_start,
	input  logic [31:0]                   nonce_count,
	input  logic [`CHUNK1_BYTES-1:0][7:0] chunk_1,
	input  logic [`CHUNK2_BYTES-1:0][7:0] chunk_2,
	input  logic [`TARGET_BYTES-1:0][7:0] difficulty,
	output logic                          blk_start,
	output logic [511:0]                  block,
	output logic [255:0]                  chain_in,
	input  logic [255:0]                  hash_out,
	input  logic                          hash_done,
	output logic                          busy,
	output logic                          done,
	output logic                          found,
	output logic [31:0]                   found_nonce
);

	// SHA-256 initial hash value
	localparam hash_word_t SHA_IV [8] = '{
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	mine_state_t  state;
	logic [31:0]  nonce;
	logic [31:0]  remaining;
	logic [255:0] midstate;
	logic [255:0] iv;
	logic [511:0] blk_hdr1, blk_hdr2, blk_digest;
	// Double hash as a little-endian integer
	logic [255:0] hash_le;

	assign iv = {SHA_IV[0], SHA_IV[1], SHA_IV[2], SHA_IV[3],
		SHA_IV[4], SHA_IV[5], SHA_IV[6], SHA_IV[7]};

	// Padded message blocks, header byte 0 in the top byte
	always_comb
	begin
		for (int i = 0; i < `CHUNK1_BYTES; i++)
			blk_hdr1[511 - 8*i -: 8] = chunk_1[i];
		// 80-byte message length in bits
		blk_hdr2[383:0] = {8'h80, 312'd0, 64'((`CHUNK1_BYTES + `CHUNK2_BYTES) * 8)};
		blk_hdr2[415:384] = {nonce[7:0], nonce[15:8], nonce[23:16], nonce[31:24]};
		for (int i = 0; i < `CHUNK2_BYTES - 4; i++)
			blk_hdr2[511 - 8*i -: 8] = chunk_2[i];
		// 32-byte digest, 256 bits long
		blk_digest = {hash_out, 8'h80, 184'd0, 64'd256};
		for (int k = 0; k < 32; k++)
			hash_le[8*k +: 8] = hash_out[255 - 8*k -: 8];
	end

	// Core inputs follow the state, latched by the core on blk_start
	assign block = (state == MIDSTATE) ? blk_hdr1 : (state == OUTER) ? blk_digest : blk_hdr2;
	assign chain_in = (state == INNER) ? midstate : iv;
	assign busy = (state != IDLE);

	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			blk_start <= 1'b0;
			done <= 1'b0;
			found <= 1'b0;
			found_nonce <= '0;
			remaining <= '0;
		end
		else
		begin
			blk_start <= 1'b0;
			case (state)
				IDLE:
					if (start)
					begin
						done <= 1'b0;
						found <= 1'b0;
						remaining <= nonce_count;
						blk_start <= 1'b1;
						state <= MIDSTATE;
					end
				MIDSTATE:
					if (hash_done)
					begin
						blk_start <= (remaining != '0);
						state <= (remaining != '0) ? INNER : DONE;
					end
				INNER:
					if (hash_done)
					begin
						blk_start <= 1'b1;
						state <= OUTER;
					end
				OUTER:
					if (hash_done)
						state <= COMPARE;
				COMPARE:
				begin
					remaining <= remaining - 32'd1;
					found <= (hash_le <= difficulty);
					// Hit when hash is at or below the target
					if (hash_le <= difficulty)
					begin
						found_nonce <= nonce;
						state <= DONE;
					end
					else
						state <= NEXT;
				end
				NEXT:
				begin
					blk_start <= (remaining != '0);
					state <= (remaining != '0) ? INNER : DONE;
				end
				DONE:
				begin
					done <= 1'b1;
					state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Nonce and midstate
	always_ff @(posedge tb_clk)
	begin
		if ((state == IDLE) && start)
			nonce <= nonce_start;
		else if (state == NEXT)
			nonce <= nonce + 32'd1;
		if ((state == MIDSTATE) && hash_done)
			midstate <= hash_out;
	end

endmodule

// File: verilog/mine_pkg.sv
// Hashing types only; the state encoding is shared with the bound assertions
package mine_pkg;

	// One 32-bit SHA-256 word
	typedef logic [31:0] hash_word_t;

	// Search controller states
	typedef enum logic [2:0] {
		IDLE,
		MIDSTATE,
		INNER,
		OUTER,
		COMPARE,
		NEXT,
		DONE
	} mine_state_t;

endpackage

// File: verilog/miner_top.sv
// Single search engine behind one APB3 slave; no interrupt, completion is polled via STATUS
`timescale 1ns/1ps
`include "miner_defs.svh"

module miner_top (
	input  logic        tb_clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	// Storage write port
	logic                          data_en;
	logic [6:0]                    data_sel;
	logic [7:0]                    data;
	// Stored header and target
	logic [`CHUNK1_BYTES-1:0][7:0] chunk_1;
	logic [`CHUNK2_BYTES-1:0][7:0] chunk_2;
	logic [`TARGET_BYTES-1:0][7:0] difficulty;
	// Job control and status
	logic                          start, busy, done, found;
	logic [31:0]                   nonce_start, nonce_count, found_nonce;
	// Hash core handshake
	logic                          blk_start, hash_done;
	logic [511:0]                  block;
	logic [255:0]                  chain_in, hash_out;

	apb_miner_regs u_regs (
		.tb_clk, .rst_n,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
		.data_en, .data_sel, .data,
		.chunk_1, .chunk_2, .difficulty,
		.start, .nonce_start, .nonce_count,
		.busy, .done, .found, .found_nonce
	);

	block_storage u_storage (
		.tb_clk, .rst_n,
		.data_en, .data_sel, .data,
		.chunk_1, .chunk_2, .difficulty
	);

	mine_ctrl u_ctrl (
		.tb_clk, .rst_n,
		.start, .nonce_start, .nonce_count,
		.chunk_1, .chunk_2, .difficulty,
		.blk_start, .block, .chain_in, .hash_out, .hash_done,
		.busy, .done, .found, .found_nonce
	);

	sha256_core u_core (
		.tb_clk, .rst_n,
		.blk_start, .block, .chain_in,
		.hash_out, .hash_done
	);

endmodule

// File: verilog/sha256_core.sv
// One round per clock, single block in flight; blk_start is ignored until hash_done has pulsed
`timescale 1ns/1ps
`include "miner_defs.svh"

module sha256_core import mine_pkg::*; (
	input  logic         tb_clk,
	input  logic         rst_n,
	input  logic         blk_start,
	input  logic [511:0] block,
	input  logic [255:0] chain_in,
	output logic [255:0] hash_out,
	output logic         hash_done
);

	// Round constants
	localparam hash_word_t K [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Working variables a..h, next values, chaining value
	hash_word_t v [8];
	hash_word_t nv [8];
	hash_word_t cv [8];
	// Rolling schedule window, w[0] feeds the current round
	hash_word_t w [16];
	hash_word_t w_next;
	hash_word_t s0, s1, ch, maj, t1, t2;
	logic       running;
	logic [5:0] round;
	logic       last_round;

	function automatic hash_word_t rotr(input hash_word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	assign last_round = (round == 6'(`SHA_ROUNDS - 1));

	// Round function
	always_comb
	begin
		s1 = rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25);
		ch = (v[4] & v[5]) ^ (~v[4] & v[6]);
		t1 = v[7] + s1 + ch + K[round] + w[0];
		s0 = rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22);
		maj = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
		t2 = s0 + maj;
		nv[0] = t1 + t2;
		nv[1] = v[0];
		nv[2] = v[1];
		nv[3] = v[2];
		nv[4] = v[3] + t1;
		nv[5] = v[4];
		nv[6] = v[5];
		nv[7] = v[6];
		// W[t+16] from the window W[t..t+15]
		w_next = (rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10)) + w[9]
			+ (rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3)) + w[0];
	end

	// Sequencing: load cycle, then 64 rounds
	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			round <= '0;
			hash_done <= 1'b0;
		end
		else
		begin
			hash_done <= 1'b0;
			if (blk_start && !running)
			begin
				running <= 1'b1;
				round <= '0;
			end
			else if (running)
			begin
				if (last_round)
				begin
					running <= 1'b0;
					hash_done <= 1'b1;
				end
				else
					round <= round + 6'd1;
			end
		end
	end

	// Datapath
	always_ff @(posedge tb_clk)
	begin
		if (blk_start && !running)
		begin
			for (int i = 0; i < 8; i++)
			begin
				cv[i] <= chain_in[255 - 32*i -: 32];
				v[i] <= chain_in[255 - 32*i -: 32];
			end
			for (int i = 0; i < 16; i++)
				w[i] <= block[511 - 32*i -: 32];
		end
		else if (running)
		begin
			v <= nv;
			for (int i = 0; i < 15; i++)
				w[i] <= w[i + 1];
			w[15] <= w_next;
			// Feed-forward add on the final round
			if (last_round)
				for (int i = 0; i < 8; i++)
					hash_out[255 - 32*i -: 32] <= cv[i] + nv[i];
		end
	end

endmodule
